// File: game_top.f
hw/game_pkg.sv
hw/vga_timing.sv
hw/game_ctrl.sv
hw/screen_draw.sv
hw/output_selector.sv
hw/game_top.sv
tb/game_tb.sv

// File: hw/game_ctrl.sv
/* Game controller: command gate of one command per frame, screen FSM,
   goal, save and shot counters and the stored ball column */
module game_ctrl #(
    parameter int ROUNDS = 5
) (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::cmd_t        cmd,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  logic                  frame_start,
    output game_pkg::game_state_t state,
    output logic [2:0]            ball_column
);
    import game_pkg::*;

    localparam int               CNT_W     = $clog2(ROUNDS + 1);
    localparam logic [CNT_W-1:0] LAST_SHOT = CNT_W'(ROUNDS);

    logic             accept;
    game_state_t      state_nxt;
    logic [2:0]       column_nxt;
    logic [CNT_W-1:0] goals;
    logic [CNT_W-1:0] goals_nxt;
    logic [CNT_W-1:0] saves;
    logic [CNT_W-1:0] saves_nxt;
    logic [CNT_W-1:0] shots;
    logic [CNT_W-1:0] shots_nxt;

    assign accept = cmd_valid && cmd_ready;

    // The gate opens at each frame start and closes on an accepted command.
    // Closing wins, so a command taken at the frame start still waits a full frame
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_ready <= 1'b0;
        end else if (accept) begin
            cmd_ready <= 1'b0;
        end else if (frame_start) begin
            cmd_ready <= 1'b1;
        end
    end

    always_comb begin
        state_nxt  = state;
        column_nxt = ball_column;
        goals_nxt  = goals;
        saves_nxt  = saves;
        shots_nxt  = shots;
        if (accept) begin
            case (state)
                START: begin
                    if (cmd.op == CMD_START) begin
                        state_nxt = SHOOTER; // New game starts with clean scores
                        goals_nxt = '0;
                        saves_nxt = '0;
                        shots_nxt = '0;
                    end
                end
                SHOOTER: begin
                    if (cmd.op == CMD_SHOOT) begin
                        column_nxt = cmd.column;
                        state_nxt  = KEEPER;
                    end
                end
                KEEPER: begin
                    if (cmd.op == CMD_DIVE) begin
                        shots_nxt = shots + 1'b1;
                        if (cmd.column == ball_column) begin
                            saves_nxt = saves + 1'b1; // Keeper guessed the column
                        end else begin
                            goals_nxt = goals + 1'b1;
                        end
                        if (shots_nxt == LAST_SHOT) begin
                            if (goals_nxt > saves_nxt) begin
                                state_nxt = WINNER;
                            end else begin
                                state_nxt = LOSER; // A draw goes to the keeper
                            end
                        end else begin
                            state_nxt = SHOOTER;
                        end
                    end
                end
                WINNER, LOSER: begin
                    if (cmd.op == CMD_START) begin
                        state_nxt = START;
                    end
                end
                default: state_nxt = START;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= START;
            ball_column <= '0;
            goals       <= '0;
            saves       <= '0;
            shots       <= '0;
        end else begin
            state       <= state_nxt;
            ball_column <= column_nxt;
            goals       <= goals_nxt;
            saves       <= saves_nxt;
            shots       <= shots_nxt;
        end
    end

    ready_drops_after_accept: assert property (
        @(posedge clk) disable iff (rst) accept |=> !cmd_ready
    ) else $error("cmd_ready still high after an accepted command");

    // The game must end once the last shot is taken
    shots_bounded: assert property (
        @(posedge clk) disable iff (rst) shots <= LAST_SHOT
    ) else $error("shot counter exceeds ROUNDS");

endmodule

// File: hw/game_pkg.sv
/* Shared types of the penalty-shootout display: video bus, game states,
   player command opcodes, the command word and the marker colour */
package game_pkg;

    // One raster point with its timing flags and colour
    typedef struct packed {
        logic [10:0] hcount; // Pixel index within the line
        logic [10:0] vcount; // Line index within the frame
        logic        hsync;
        logic        vsync;
        logic        hblnk;  // High outside the active pixels of a line
        logic        vblnk;  // High outside the active lines of a frame
        logic [11:0] rgb;    // 4 bits each of red, green and blue
    } vga_bus_t;

    // Screens of the game, one renderer each
    typedef enum logic [2:0] {
        START   = 3'd0,
        SHOOTER = 3'd1,
        KEEPER  = 3'd2,
        WINNER  = 3'd3,
        LOSER   = 3'd4
    } game_state_t;

    // Player command opcodes
    typedef enum logic [1:0] {
        CMD_START = 2'd0, // Begin a game or return to the title screen
        CMD_SHOOT = 2'd1, // Shooter picks the goal column
        CMD_DIVE  = 2'd2  // Keeper picks the column to cover
    } cmd_op_t;

    // Command word on the valid/ready port
    typedef struct packed {
        cmd_op_t    op;
        logic [2:0] column; // One of the 8 goal columns
    } cmd_t;

    // Colour of the ball marker on every screen
    localparam logic [11:0] SPRITE_RGB = 12'hfff;

endpackage

// File: hw/game_top.sv
/* Display subsystem top level: raster timing, game controller,
   five screen renderers and the frame-aligned output selector */
module game_top #(
    parameter int H_ACTIVE = 800,
    parameter int H_TOTAL  = 1056,
    parameter int V_ACTIVE = 600,
    parameter int V_TOTAL  = 628,
    parameter int ROUNDS   = 5
) (
    input  logic               clk,
    input  logic               rst,
    input  game_pkg::cmd_t     cmd,
    input  logic               cmd_valid,
    output logic               cmd_ready,
    output game_pkg::vga_bus_t vga_out
);
    import game_pkg::*;

    // Background colour of each screen
    localparam logic [11:0] START_RGB   = 12'h147;
    localparam logic [11:0] SHOOTER_RGB = 12'h2a2; // Pitch green
    localparam logic [11:0] KEEPER_RGB  = 12'h25c;
    localparam logic [11:0] WINNER_RGB  = 12'hec1;
    localparam logic [11:0] LOSER_RGB   = 12'hb22;

    vga_bus_t    raster;
    logic        frame_start;
    game_state_t state;
    logic [2:0]  ball_column;
    vga_bus_t    scr_start;
    vga_bus_t    scr_shooter;
    vga_bus_t    scr_keeper;
    vga_bus_t    scr_winner;
    vga_bus_t    scr_loser;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_TOTAL (H_TOTAL),
        .V_ACTIVE(V_ACTIVE),
        .V_TOTAL (V_TOTAL)
    ) u_timing (
        .clk        (clk),
        .rst        (rst),
        .raster     (raster),
        .frame_start(frame_start)
    );

    game_ctrl #(.ROUNDS(ROUNDS)) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .frame_start(frame_start),
        .state      (state),
        .ball_column(ball_column)
    );

    screen_draw #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .BG_RGB(START_RGB)) u_draw_start (
        .clk(clk), .rst(rst), .raster(raster), .ball_column(ball_column), .screen(scr_start)
    );

    screen_draw #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .BG_RGB(SHOOTER_RGB)) u_draw_shooter (
        .clk(clk), .rst(rst), .raster(raster), .ball_column(ball_column), .screen(scr_shooter)
    );

    screen_draw #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .BG_RGB(KEEPER_RGB)) u_draw_keeper (
        .clk(clk), .rst(rst), .raster(raster), .ball_column(ball_column), .screen(scr_keeper)
    );

    screen_draw #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .BG_RGB(WINNER_RGB)) u_draw_winner (
        .clk(clk), .rst(rst), .raster(raster), .ball_column(ball_column), .screen(scr_winner)
    );

    screen_draw #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .BG_RGB(LOSER_RGB)) u_draw_loser (
        .clk(clk), .rst(rst), .raster(raster), .ball_column(ball_column), .screen(scr_loser)
    );

    output_selector u_sel (
        .clk       (clk),
        .rst       (rst),
        .in_start  (scr_start),
        .in_shooter(scr_shooter),
        .in_keeper (scr_keeper),
        .in_winner (scr_winner),
        .in_loser  (scr_loser),
        .state     (state),
        .vga_out   (vga_out)
    );

endmodule

// File: hw/output_selector.sv
/* Output stage: picks the bus of the displayed screen, switching screens
   only at the first pixel of a frame, and registers it */
module output_selector (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::vga_bus_t    in_start,
    input  game_pkg::vga_bus_t    in_shooter,
    input  game_pkg::vga_bus_t    in_keeper,
    input  game_pkg::vga_bus_t    in_winner,
    input  game_pkg::vga_bus_t    in_loser,
    input  game_pkg::game_state_t state,
    output game_pkg::vga_bus_t    vga_out
);
    import game_pkg::*;

    game_state_t shown;     // Screen currently on the display
    game_state_t shown_nxt;
    logic        at_origin;
    vga_bus_t    selected;

    // All renderers share one raster, so the START bus stands for them all
    assign at_origin = (in_start.hcount == 11'd0) && (in_start.vcount == 11'd0);

    // The new screen applies from pixel (0,0) itself, so the whole frame matches
    always_comb begin
        if (at_origin) begin
            shown_nxt = state;
        end else begin
            shown_nxt = shown;
        end
    end

    always_comb begin
        case (shown_nxt)
            START:   selected = in_start;
            SHOOTER: selected = in_shooter;
            KEEPER:  selected = in_keeper;
            WINNER:  selected = in_winner;
            LOSER:   selected = in_loser;
            default: selected = in_start;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            shown   <= START;
            vga_out <= '0; // Syncs and blanks inactive until the raster arrives
        end else begin
            shown   <= shown_nxt;
            vga_out <= selected;
        end
    end

    // A screen switch mid-frame would tear the picture
    switch_at_frame_start: assert property (
        @(posedge clk) disable iff (rst) !$stable(shown) |-> $past(at_origin)
    ) else $error("displayed screen changed away from pixel (0,0)");

endmodule

// File: hw/screen_draw.sv
/* Screen renderer: solid background with the ball marker box,
   one register stage on the raster bus */
module screen_draw #(
    parameter int          H_ACTIVE = 800,
    parameter int          V_ACTIVE = 600,
    parameter logic [11:0] BG_RGB   = 12'h000
) (
    input  logic               clk,
    input  logic               rst,
    input  game_pkg::vga_bus_t raster,
    input  logic [2:0]         ball_column,
    output game_pkg::vga_bus_t screen
);
    import game_pkg::*;

    // Each goal column is one eighth of the line wide
    localparam logic [10:0] COL_W   = 11'(H_ACTIVE / 8);
    localparam logic [10:0] BOX_TOP = 11'(3 * V_ACTIVE / 8);
    localparam logic [10:0] BOX_BOT = 11'(5 * V_ACTIVE / 8);

    logic [10:0] box_left;
    logic [10:0] box_right;
    logic        in_box;
    vga_bus_t    pixel;

    assign box_left  = 11'(ball_column) * COL_W;
    assign box_right = box_left + COL_W;

    always_comb begin
        in_box = (raster.hcount >= box_left) && (raster.hcount < box_right) &&
                 (raster.vcount >= BOX_TOP) && (raster.vcount < BOX_BOT);
        pixel = raster;
        if (raster.hblnk || raster.vblnk) begin
            pixel.rgb = '0; // Blanked pixels must be black
        end else if (in_box) begin
            pixel.rgb = SPRITE_RGB;
        end else begin
            pixel.rgb = BG_RGB;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            screen <= '0;
        end else begin
            screen <= pixel;
        end
    end

endmodule

// File: hw/vga_timing.sv
/* Raster generator: wrapping pixel and line counters with sync pulses,
   blanking flags and a pulse at the first pixel of each frame */
module vga_timing #(
    parameter int H_ACTIVE = 800,
    parameter int H_TOTAL  = 1056,
    parameter int V_ACTIVE = 600,
    parameter int V_TOTAL  = 628
) (
    input  logic               clk,
    input  logic               rst,
    output game_pkg::vga_bus_t raster,
    output logic               frame_start
);

    localparam logic [10:0] H_LAST = 11'(H_TOTAL - 1);
    localparam logic [10:0] V_LAST = 11'(V_TOTAL - 1);
    localparam logic [10:0] H_END  = 11'(H_ACTIVE);
    localparam logic [10:0] V_END  = 11'(V_ACTIVE);

    // Sync pulses cover the middle half of each blanking interval
    localparam logic [10:0] H_SYNC_START = 11'(H_ACTIVE + (H_TOTAL - H_ACTIVE) / 4);
    localparam logic [10:0] H_SYNC_END   = 11'(H_ACTIVE + 3 * (H_TOTAL - H_ACTIVE) / 4);
    localparam logic [10:0] V_SYNC_START = 11'(V_ACTIVE + (V_TOTAL - V_ACTIVE) / 4);
    localparam logic [10:0] V_SYNC_END   = 11'(V_ACTIVE + 3 * (V_TOTAL - V_ACTIVE) / 4);

    logic [10:0] hcount;
    logic [10:0] vcount;

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == H_LAST) begin
            hcount <= '0;
            if (vcount == V_LAST) begin
                vcount <= '0; // Frame wraps back to the top line
            end else begin
                vcount <= vcount + 11'd1;
            end
        end else begin
            hcount <= hcount + 11'd1;
        end
    end

    // Timing flags decode straight from the counters so all fields stay aligned
    always_comb begin
        raster.hcount = hcount;
        raster.vcount = vcount;
        raster.hblnk  = (hcount >= H_END);
        raster.vblnk  = (vcount >= V_END);
        raster.hsync  = (hcount >= H_SYNC_START) && (hcount < H_SYNC_END);
        raster.vsync  = (vcount >= V_SYNC_START) && (vcount < V_SYNC_END);
        raster.rgb    = '0; // Colour is filled in by the renderers
    end

    assign frame_start = (hcount == 11'd0) && (vcount == 11'd0);

    // Pixel counter must stay inside the line
    hcount_bounded: assert property (
        @(posedge clk) disable iff (rst) hcount < 11'(H_TOTAL)
    ) else $error("hcount out of range");

endmodule

// File: tb/game_tb.sv
/* Testbench for the display subsystem: clock, reset, random player commands,
   a reference model of game and raster, and per-pixel output checks */
module game_tb;
    import game_pkg::*;

    localparam int H_ACTIVE      = 16;
    localparam int H_TOTAL       = 20;
    localparam int V_ACTIVE      = 8;
    localparam int V_TOTAL       = 10;
    localparam int ROUNDS        = 3;
    localparam int FRAME         = H_TOTAL * V_TOTAL;
    localparam int NUM_COMMANDS  = 60;
    localparam int READY_TIMEOUT = 3 * FRAME; // One frame is always enough for a transfer
    localparam int RUN_TIMEOUT   = 4 * FRAME * NUM_COMMANDS;

    logic     clk;
    logic     rst;
    cmd_t     cmd;
    logic     cmd_valid;
    logic     cmd_ready;
    vga_bus_t vga_out;

    integer seed;
    int     cycles;
    int     wait_cycles;
    int     accepted;
    int     games_done;

    // Reference model of raster counters, game state and the two video stages
    int          m_h;
    int          m_v;
    logic        m_ready;
    logic        m_accept;
    game_state_t m_state;
    logic [2:0]  m_col;
    int          goals;
    int          saves;
    int          shots;
    vga_bus_t    s1_bus;   // Raster point one cycle old
    logic [2:0]  s1_col;   // Ball column seen by the renderers with that point
    logic        s1_valid;
    game_state_t shown;    // Screen the display is expected to show
    vga_bus_t    exp_out;

    game_top #(
        .H_ACTIVE(H_ACTIVE),
        .H_TOTAL (H_TOTAL),
        .V_ACTIVE(V_ACTIVE),
        .V_TOTAL (V_TOTAL),
        .ROUNDS  (ROUNDS)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .vga_out  (vga_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic vga_bus_t raster_point(int h, int v);
        vga_bus_t p;
        p        = '0;
        p.hcount = 11'(h);
        p.vcount = 11'(v);
        p.hblnk  = (h >= H_ACTIVE);
        p.vblnk  = (v >= V_ACTIVE);
        // Sync pulses cover the middle half of each blanking interval
        p.hsync  = (h >= H_ACTIVE + (H_TOTAL - H_ACTIVE) / 4) &&
                   (h < H_ACTIVE + 3 * (H_TOTAL - H_ACTIVE) / 4);
        p.vsync  = (v >= V_ACTIVE + (V_TOTAL - V_ACTIVE) / 4) &&
                   (v < V_ACTIVE + 3 * (V_TOTAL - V_ACTIVE) / 4);
        return p;
    endfunction

    function automatic logic [11:0] background_of(game_state_t s);
        case (s)
            SHOOTER: return 12'h2a2;
            KEEPER:  return 12'h25c;
            WINNER:  return 12'hec1;
            LOSER:   return 12'hb22;
            default: return 12'h147;
        endcase
    endfunction

    function automatic vga_bus_t paint_pixel(vga_bus_t p, logic [2:0] col, game_state_t s);
        int       h;
        int       v;
        vga_bus_t q;
        h = p.hcount;
        v = p.vcount;
        q = p;
        if (p.hblnk || p.vblnk) begin
            q.rgb = '0;
        end else if ((h / (H_ACTIVE / 8) == int'(col)) && (v >= V_ACTIVE / 2 - V_ACTIVE / 8) &&
                     (v < V_ACTIVE / 2 + V_ACTIVE / 8)) begin
            q.rgb = SPRITE_RGB; // Ball box in the middle quarter of the lines
        end else begin
            q.rgb = background_of(s);
        end
        return q;
    endfunction

    task automatic apply_command(cmd_t c);
        case (m_state)
            START: begin
                if (c.op == CMD_START) begin
                    m_state = SHOOTER;
                    goals   = 0;
                    saves   = 0;
                    shots   = 0;
                end
            end
            SHOOTER: begin
                if (c.op == CMD_SHOOT) begin
                    m_col   = c.column;
                    m_state = KEEPER;
                end
            end
            KEEPER: begin
                if (c.op == CMD_DIVE) begin
                    shots++;
                    if (c.column == m_col) begin
                        saves++;
                    end else begin
                        goals++;
                    end
                    if (shots == ROUNDS) begin
                        m_state = (goals > saves) ? WINNER : LOSER;
                        games_done++;
                    end else begin
                        m_state = SHOOTER;
                    end
                end
            end
            default: begin
                if (c.op == CMD_START) begin
                    m_state = START;
                end
            end
        endcase
    endtask

    // Model advances on the rising edge and updates its stages oldest first
    always @(posedge clk) begin
        if (rst) begin
            m_h      = 0;
            m_v      = 0;
            m_ready  = 1'b0;
            m_accept = 1'b0;
            m_state  = START;
            m_col    = '0;
            goals    = 0;
            saves    = 0;
            shots    = 0;
            s1_bus   = '0;
            s1_col   = '0;
            s1_valid = 1'b0;
            shown    = START;
            exp_out  = '0;
        end else begin
            m_accept = cmd_valid && m_ready;
            if (s1_bus.hcount == 11'd0 && s1_bus.vcount == 11'd0) begin
                shown = m_state; // Screen switches only at pixel (0,0)
            end
            exp_out  = s1_valid ? paint_pixel(s1_bus, s1_col, shown) : '0;
            s1_bus   = raster_point(m_h, m_v);
            s1_col   = m_col;
            s1_valid = 1'b1;
            if (m_accept) begin
                m_ready = 1'b0;
                accepted++;
                apply_command(cmd);
            end else if (m_h == 0 && m_v == 0) begin
                m_ready = 1'b1;
            end
            if (m_h == H_TOTAL - 1) begin
                m_h = 0;
                m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
            end else begin
                m_h = m_h + 1;
            end
        end
    end

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_outputs();
        vga_bus_t got_t;
        vga_bus_t exp_t;
        got_t     = vga_out;
        got_t.rgb = '0;
        exp_t     = exp_out;
        exp_t.rgb = '0;
        timing_ok: assert (got_t == exp_t) else begin
            $display("[FAIL] vga_out timing fields expected %h got %h", exp_t, got_t);
            stop_with_failure();
        end
        rgb_ok: assert (vga_out.rgb == exp_out.rgb) else begin
            $display("[FAIL] vga_out.rgb expected %h got %h at pixel %h,%h",
                     exp_out.rgb, vga_out.rgb, exp_out.hcount, exp_out.vcount);
            stop_with_failure();
        end
        ready_ok: assert (cmd_ready == m_ready) else begin
            $display("[FAIL] cmd_ready expected %h got %h", m_ready, cmd_ready);
            stop_with_failure();
        end
    endtask

    // Mostly commands that fit the current screen, so that games run to the end
    task automatic pick_command(output cmd_t c);
        int r;
        r = $random(seed) & 3;
        if (r != 0) begin
            case (m_state)
                SHOOTER: c.op = CMD_SHOOT;
                KEEPER:  c.op = CMD_DIVE;
                default: c.op = CMD_START;
            endcase
        end else begin
            c.op = cmd_op_t'(($random(seed) & 32'h7fff_ffff) % 3);
        end
        c.column = 3'($random(seed));
        if (c.op == CMD_DIVE && (($random(seed) & 1) == 1)) begin
            c.column = m_col; // Keeper guesses right about half the time
        end
    endtask

    task automatic drive_command();
        if (cmd_valid && !m_accept) begin
            wait_cycles++; // Command held stable until the transfer
            if (wait_cycles > READY_TIMEOUT) begin
                $display("cmd_ready stayed low for %0d cycles with a command waiting",
                         wait_cycles);
                stop_with_failure();
            end
        end else begin
            wait_cycles = 0;
            cmd_valid   = (($random(seed) & 3) != 0);
            pick_command(cmd);
        end
    endtask

    initial begin
        seed        = 32'h02571291;
        rst         = 1'b1;
        cmd         = '0;
        cmd_valid   = 1'b0;
        cycles      = 0;
        wait_cycles = 0;
        accepted    = 0;
        games_done  = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        while (accepted < NUM_COMMANDS && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            check_outputs();
            drive_command();
        end
        if (accepted < NUM_COMMANDS) begin
            $display("Timed out after %0d cycles with %0d commands accepted", cycles, accepted);
            stop_with_failure();
        end else if (games_done == 0) begin
            $display("No game reached the winner or loser screen");
            stop_with_failure();
        end else begin
            $display("Commands accepted: %0d, games finished: %0d", accepted, games_done);
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule
